// ==== common/hl_cfg_pkg.sv ====
package hl_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Board identity
  ////////////////////////////////////////////////////////////

  // Reported in every response word
  localparam logic [7:0] SERIAL_NO = 8'd67;

  ////////////////////////////////////////////////////////////
  // Host frame format
  ////////////////////////////////////////////////////////////

  // First byte of a frame selects its type
  localparam logic [7:0] FRAME_START = 8'h5a;
  localparam logic [7:0] FRAME_CMD   = 8'hc3;

  // Command addresses carried in header bits 7:2
  localparam logic [5:0] ADDR_CFG    = 6'h00;
  localparam logic [5:0] ADDR_AD9866 = 6'h3b;

  ////////////////////////////////////////////////////////////
  // Converter serial bus
  ////////////////////////////////////////////////////////////

  // clk_ctrl cycles per half period of sclk
  localparam int SPI_HALF = 2;

  // Register address byte plus value byte
  localparam int SPI_BITS = 16;

  ////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////

  // Command counter wraps silently at this width
  localparam int CNT_W = 16;

endpackage

// ==== common/hl_proto_pkg.sv ====
package hl_proto_pkg;

  ////////////////////////////////////////////////////////////
  // Two views of the same 32-bit command data word
  ////////////////////////////////////////////////////////////

  // General configuration
  typedef struct packed {
    logic [29:0] rsvd;
    logic        ad9866_rst;   // Holds converter in reset
    logic        cw_key;
  } cfg_word_t;

  // Converter register write
  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  reg_addr;
    logic [7:0]  value;
  } spi_word_t;

  typedef union packed {
    logic [31:0] raw;
    cfg_word_t   cfg;
    spi_word_t   spi;
  } cmd_data_u;

  ////////////////////////////////////////////////////////////
  // 40-bit response word
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       run;
    logic       tx_on;
    logic       cw_key;
    logic       clip;        // Sticky since last response
    logic       goodlvl;     // Sticky since last response
    logic       spi_busy;
    logic [1:0] zero;
  } resp_flags_t;

  typedef struct packed {
    logic [5:0]                   addr;
    logic                         ptt;
    logic                         valid_one;
    logic [7:0]                   serial;
    resp_flags_t                  flags;
    logic [hl_cfg_pkg::CNT_W-1:0] count;
  } resp_t;

endpackage

// ==== common/cmd_if.sv ====
`timescale 1ns/1ps

interface cmd_if;

  logic                    valid;
  logic [5:0]              addr;
  hl_proto_pkg::cmd_data_u data;
  logic                    ptt;
  logic                    resp_req;

  // Frame parser drives one command per valid pulse
  modport src (output valid, addr, data, ptt, resp_req);

  // Register block and response builder
  modport dst (input valid, addr, data, ptt, resp_req);

endinterface

// ==== source/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  logic [7:0] udp_rx_data_i,
  input  logic       udp_rx_active_i,
  output logic       run_o,
  cmd_if.src         cmd
);

  // Byte position within the current frame saturates at 7
  logic [2:0]  pos_q;

  // Frame type seen in byte 0 until the frame is consumed
  logic        start_q;
  logic        cmd_q;

  logic [7:0]  hdr_q;
  logic [23:0] data_q;

  ////////////////////////////////////////////////////////////
  // Frame tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pos_q     <= 3'd0;
      start_q   <= 1'b0;
      cmd_q     <= 1'b0;
      run_o     <= 1'b0;
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= 1'b0;
      if (!udp_rx_active_i) begin
        // Short frames end up here and are dropped
        pos_q   <= 3'd0;
        start_q <= 1'b0;
        cmd_q   <= 1'b0;
      end else begin
        if (pos_q != 3'd7) begin
          pos_q <= pos_q + 3'd1;
        end
        if (pos_q == 3'd0) begin
          start_q <= (udp_rx_data_i == hl_cfg_pkg::FRAME_START);
          cmd_q   <= (udp_rx_data_i == hl_cfg_pkg::FRAME_CMD);
        end
        if (start_q) begin
          run_o   <= udp_rx_data_i[0];
          start_q <= 1'b0;
        end
        if (cmd_q && pos_q == 3'd5) begin
          cmd.valid <= 1'b1;
          cmd_q     <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Header and data assembly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (udp_rx_active_i && cmd_q) begin
      if (pos_q == 3'd1) begin
        hdr_q <= udp_rx_data_i;
      end else if (pos_q == 3'd5) begin
        // Everything is published together on the last data byte
        cmd.addr     <= hdr_q[7:2];
        cmd.resp_req <= hdr_q[1];
        cmd.ptt      <= hdr_q[0];
        cmd.data.raw <= {data_q, udp_rx_data_i};
      end else begin
        // MSB first
        data_q <= {data_q[15:0], udp_rx_data_i};
      end
    end
  end

endmodule

// ==== control/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  cmd_if.dst          cmd,
  input  logic        run_i,
  output logic        tx_on_o,
  output logic        cw_keydown_o,
  output logic        ad9866_rst_n_o,
  output logic        spi_start_o,
  output logic [15:0] spi_word_o
);

  logic ptt_q;
  logic cw_key_q;
  logic conv_rst_q;

  // Address decode of the current command
  logic is_cfg;
  logic is_conv;

  assign is_cfg  = cmd.valid && (cmd.addr == hl_cfg_pkg::ADDR_CFG);
  assign is_conv = cmd.valid && (cmd.addr == hl_cfg_pkg::ADDR_AD9866);

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptt_q       <= 1'b0;
      cw_key_q    <= 1'b0;
      conv_rst_q  <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      // One pulse per converter command
      spi_start_o <= is_conv;

      // Every command carries the PTT state
      if (cmd.valid) begin
        ptt_q <= cmd.ptt;
      end

      if (is_cfg) begin
        cw_key_q   <= cmd.data.cfg.cw_key;
        conv_rst_q <= cmd.data.cfg.ad9866_rst;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Converter word
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (is_conv) begin
      spi_word_o <= {cmd.data.spi.reg_addr, cmd.data.spi.value};
    end
  end

  // Transmit only while running
  assign tx_on_o        = run_i & ptt_q;
  assign cw_keydown_o   = cw_key_q;
  assign ad9866_rst_n_o = ~conv_rst_q;

endmodule

// ==== control/spi_writer.sv ====
`timescale 1ns/1ps

module spi_writer (
  input  logic                            clk_ctrl,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  input  logic [hl_cfg_pkg::SPI_BITS-1:0] word_i,
  output logic                            busy_o,
  output logic                            sclk_o,
  output logic                            sdio_o,
  output logic                            sen_n_o
);

  // Half period divider
  logic [3:0] div_q;
  // Bits already completed in this window
  logic [4:0] bit_q;
  logic [hl_cfg_pkg::SPI_BITS-1:0] shift_q;

  logic half_done;
  logic last_bit;

  assign half_done = (div_q == 4'(hl_cfg_pkg::SPI_HALF - 1));
  assign last_bit  = (bit_q == 5'(hl_cfg_pkg::SPI_BITS - 1));

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q   <= 4'd0;
      bit_q   <= 5'd0;
      shift_q <= '0;
      sclk_o  <= 1'b0;
      sen_n_o <= 1'b1;
    end else if (sen_n_o) begin
      // Start pulses are taken only while idle
      sclk_o <= 1'b0;
      if (start_i) begin
        sen_n_o <= 1'b0;
        shift_q <= word_i;
        div_q   <= 4'd0;
        bit_q   <= 5'd0;
      end
    end else if (half_done) begin
      div_q <= 4'd0;
      if (!sclk_o) begin
        // Rising edge, receiver samples sdio
        sclk_o <= 1'b1;
      end else begin
        sclk_o <= 1'b0;
        if (last_bit) begin
          sen_n_o <= 1'b1;
        end else begin
          bit_q   <= bit_q + 5'd1;
          shift_q <= {shift_q[hl_cfg_pkg::SPI_BITS-2:0], 1'b0};
        end
      end
    end else begin
      div_q <= div_q + 4'd1;
    end
  end

  // Data moves on the falling edge only
  assign sdio_o = shift_q[hl_cfg_pkg::SPI_BITS-1];
  assign busy_o = ~sen_n_o;

endmodule

// ==== control/resp_builder.sv ====
`timescale 1ns/1ps

module resp_builder (
  input  logic                clk_ctrl,
  input  logic                rst_n_i,
  cmd_if.dst                  cmd,
  input  logic                run_i,
  input  logic                tx_on_i,
  input  logic                cw_keydown_i,
  input  logic                spi_busy_i,
  input  logic                rxclip_i,
  input  logic                rxgoodlvl_i,
  output hl_proto_pkg::resp_t resp_o,
  output logic                resp_valid_o
);

  logic [hl_cfg_pkg::CNT_W-1:0] cmd_cnt_q;
  logic                         clip_q;
  logic                         good_q;

  // Echo fields of the last command
  logic [5:0] addr_q;
  logic       ptt_q;

  hl_proto_pkg::resp_t resp_now;
  hl_proto_pkg::resp_t resp_hold;

  ////////////////////////////////////////////////////////////
  // Counter, sticky status and response hold
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_cnt_q    <= '0;
      clip_q       <= 1'b0;
      good_q       <= 1'b0;
      resp_valid_o <= 1'b0;
      resp_hold    <= '0;
    end else begin
      resp_valid_o <= cmd.valid & cmd.resp_req;
      if (cmd.valid) begin
        cmd_cnt_q <= cmd_cnt_q + 1'b1;
      end
      // Cleared once reported unless a new pulse arrives
      clip_q <= rxclip_i | (clip_q & ~resp_valid_o);
      good_q <= rxgoodlvl_i | (good_q & ~resp_valid_o);
      if (resp_valid_o) begin
        resp_hold <= resp_now;
      end
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd.valid) begin
      addr_q <= cmd.addr;
      ptt_q  <= cmd.ptt;
    end
  end

  // Register outputs already reflect the command in the valid cycle
  always_comb begin
    resp_now                = '0;
    resp_now.addr           = addr_q;
    resp_now.ptt            = ptt_q;
    resp_now.valid_one      = 1'b1;
    resp_now.serial         = hl_cfg_pkg::SERIAL_NO;
    resp_now.flags.run      = run_i;
    resp_now.flags.tx_on    = tx_on_i;
    resp_now.flags.cw_key   = cw_keydown_i;
    resp_now.flags.clip     = clip_q;
    resp_now.flags.goodlvl  = good_q;
    resp_now.flags.spi_busy = spi_busy_i;
    resp_now.count          = cmd_cnt_q;
  end

  assign resp_o = resp_valid_o ? resp_now : resp_hold;

endmodule

// ==== source/hl_ctrl_top.sv ====
`timescale 1ns/1ps

module hl_ctrl_top (
  input  logic        clk_ctrl,
  input  logic        rst_n_i,

  // Host byte stream
  input  logic [7:0]  udp_rx_data_i,
  input  logic        udp_rx_active_i,

  // Receiver status
  input  logic        rxclip_i,
  input  logic        rxgoodlvl_i,

  // Radio control
  output logic        run_o,
  output logic        tx_on_o,
  output logic        cw_keydown_o,

  // Converter
  output logic        ad9866_rst_n_o,
  output logic        ad9866_sclk_o,
  output logic        ad9866_sdio_o,
  output logic        ad9866_sen_n_o,

  // Response to host
  output logic [39:0] resp_o,
  output logic        resp_valid_o
);

  logic        spi_start;
  logic [15:0] spi_word;
  logic        spi_busy;

  cmd_if cmd_bus ();

  cmd_parser u_parser (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .udp_rx_data_i   (udp_rx_data_i),
    .udp_rx_active_i (udp_rx_active_i),
    .run_o           (run_o),
    .cmd             (cmd_bus.src)
  );

  ctrl_regs u_regs (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .cmd             (cmd_bus.dst),
    .run_i           (run_o),
    .tx_on_o         (tx_on_o),
    .cw_keydown_o    (cw_keydown_o),
    .ad9866_rst_n_o  (ad9866_rst_n_o),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  spi_writer u_spi (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .start_i         (spi_start),
    .word_i          (spi_word),
    .busy_o          (spi_busy),
    .sclk_o          (ad9866_sclk_o),
    .sdio_o          (ad9866_sdio_o),
    .sen_n_o         (ad9866_sen_n_o)
  );

  resp_builder u_resp (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .cmd             (cmd_bus.dst),
    .run_i           (run_o),
    .tx_on_i         (tx_on_o),
    .cw_keydown_i    (cw_keydown_o),
    .spi_busy_i      (spi_busy),
    .rxclip_i        (rxclip_i),
    .rxgoodlvl_i     (rxgoodlvl_i),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o)
  );

endmodule

// ==== bench/hl_ctrl_assertions.sv ====
`timescale 1ns/1ps

module hl_ctrl_assertions (
  input logic        clk_ctrl,
  input logic        rst_n_i,
  input logic        run_i,
  input logic        tx_on_i,
  input logic        sclk_i,
  input logic        sen_n_i,
  input logic [39:0] resp_i,
  input logic        resp_valid_i
);

  hl_proto_pkg::resp_t resp;

  assign resp = resp_i;

  // Transmit needs the radio running
  tx_needs_run: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    tx_on_i |-> run_i)
    else $error("tx_on high while run is low");

  resp_single_cycle: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_valid_i |=> !resp_valid_i)
    else $error("resp_valid held for two cycles");

  // Serial clock only toggles inside the chip enable window
  sclk_idle_low: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    sen_n_i |-> !sclk_i)
    else $error("sclk high while sen_n is high");

  // Response word holds between responses
  resp_held: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !resp_valid_i |-> $stable(resp))
    else $error("response word changed without resp_valid");

endmodule

bind hl_ctrl_top hl_ctrl_assertions u_assertions (
  .clk_ctrl     (clk_ctrl),
  .rst_n_i      (rst_n_i),
  .run_i        (run_o),
  .tx_on_i      (tx_on_o),
  .sclk_i       (ad9866_sclk_o),
  .sen_n_i      (ad9866_sen_n_o),
  .resp_i       (resp_o),
  .resp_valid_i (resp_valid_o)
);

// ==== bench/tb_hl_ctrl.sv ====
`timescale 1ns/1ps

module tb_hl_ctrl;

  localparam int NUM_FRAMES  = 40;
  // Worst frame is about 130 cycles with waits, so 40 frames stay near 5200
  localparam int CYCLE_LIMIT = 10000;

  logic        clk_ctrl;
  logic        rst_n_i;
  logic [7:0]  udp_rx_data_i;
  logic        udp_rx_active_i;
  logic        rxclip_i;
  logic        rxgoodlvl_i;
  logic        run_o;
  logic        tx_on_o;
  logic        cw_keydown_o;
  logic        ad9866_rst_n_o;
  logic        ad9866_sclk_o;
  logic        ad9866_sdio_o;
  logic        ad9866_sen_n_o;
  logic [39:0] resp_o;
  logic        resp_valid_o;

  logic [31:0] rng;
  logic [7:0]  frame_q[$];
  int          frame_no;
  int          cycles      = 0;
  int          resp_seen   = 0;
  int          spi_windows = 0;
  logic [15:0] spi_shift   = '0;
  logic [15:0] spi_last    = '0;
  logic        sclk_prev   = 1'b0;
  logic        sen_prev    = 1'b1;

  // Reference model state
  logic        m_run;
  logic        m_ptt;
  logic        m_cw;
  logic        m_conv_rst;
  logic        m_clip;
  logic        m_good;
  logic [15:0] m_count;
  int          m_resp;
  int          m_windows;

  hl_ctrl_top UUT (.*);

  initial begin
    clk_ctrl = 1'b0;
    forever #4 clk_ctrl = ~clk_ctrl;
  end

  always @(posedge clk_ctrl) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_with_failure("Timeout, the run went past its cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk_ctrl) begin
    if (resp_valid_o) begin
      resp_seen <= resp_seen + 1;
    end
    // Converter samples sdio on the rising sclk edge
    if (ad9866_sclk_o && !sclk_prev && !ad9866_sen_n_o) begin
      spi_shift <= {spi_shift[14:0], ad9866_sdio_o};
    end
    if (ad9866_sen_n_o && !sen_prev) begin
      spi_windows <= spi_windows + 1;
      spi_last    <= spi_shift;
    end
    sclk_prev <= ad9866_sclk_o;
    sen_prev  <= ad9866_sen_n_o;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [39:0] exp, input logic [39:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail frame %0d %s: expected %h, actual %h",
                                  frame_no, name, exp, act));
    end
  endtask

  task automatic send_frame();
    foreach (frame_q[k]) begin
      @(negedge clk_ctrl);
      udp_rx_active_i = 1'b1;
      udp_rx_data_i   = frame_q[k];
    end
    @(negedge clk_ctrl);
    udp_rx_active_i = 1'b0;
    udp_rx_data_i   = 8'h00;
  endtask

  task automatic wait_response();
    int n;
    n = 0;
    while (!resp_valid_o) begin
      @(negedge clk_ctrl);
      n++;
      if (n > 8) begin
        stop_with_failure($sformatf("No response to command frame %0d", frame_no));
      end
    end
  endtask

  task automatic wait_spi_done();
    int n;
    n = 0;
    while (spi_windows < m_windows) begin
      @(negedge clk_ctrl);
      n++;
      if (n > 100) begin
        stop_with_failure($sformatf("Serial write of frame %0d never ended", frame_no));
      end
    end
  endtask

  // Status pulses land only in the middle of a gap
  task automatic idle_gap(input int len);
    for (int c = 0; c < len; c++) begin
      @(negedge clk_ctrl);
      rxclip_i    = 1'b0;
      rxgoodlvl_i = 1'b0;
      if (c == len / 2) begin
        rng         = xorshift(rng);
        rxclip_i    = rng[0] & rng[1];
        rxgoodlvl_i = rng[2] & rng[3];
        m_clip      = m_clip | rxclip_i;
        m_good      = m_good | rxgoodlvl_i;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  initial begin
    logic [5:0]  addr;
    logic [31:0] data;
    logic        is_cmd;
    rng = 32'h22895ae8;
    rst_n_i = 1'b0;
    udp_rx_data_i = 8'h00;
    udp_rx_active_i = 1'b0;
    rxclip_i = 1'b0;
    rxgoodlvl_i = 1'b0;
    {m_run, m_ptt, m_cw, m_conv_rst, m_clip, m_good} = '0;
    m_count = '0;
    m_resp = 0;
    m_windows = 0;
    frame_no = 0;
    repeat (16) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    rst_n_i = 1'b1;
    check_value("reset state", 40'b0000110,
                {run_o, tx_on_o, cw_keydown_o, resp_valid_o,
                 ad9866_sen_n_o, ad9866_rst_n_o, ad9866_sclk_o});

    for (int i = 0; i < NUM_FRAMES; i++) begin
      frame_no = i;
      rng  = xorshift(rng);
      data = xorshift(rng);
      addr = '0;
      is_cmd = 1'b0;
      frame_q.delete();
      if (rng[2:0] < 3'd2) begin
        frame_q.push_back(hl_cfg_pkg::FRAME_START);
        frame_q.push_back(data[7:0]);
        m_run = data[0];
        if (rng[13]) frame_q.push_back(rng[31:24]);
      end else if (rng[2:0] == 3'd2) begin
        // Malformed frames leave every output alone
        case (rng[5:4])
          2'd2: frame_q.push_back(hl_cfg_pkg::FRAME_START);
          2'd3: begin
            frame_q.push_back(hl_cfg_pkg::FRAME_CMD);
            for (int k = 0; k <= int'(rng[7:6]); k++) frame_q.push_back(data[8*k +: 8]);
          end
          default: begin
            frame_q.push_back((data[31:24] == hl_cfg_pkg::FRAME_START ||
                               data[31:24] == hl_cfg_pkg::FRAME_CMD) ? 8'h00 : data[31:24]);
            frame_q.push_back(data[7:0]);
          end
        endcase
      end else begin
        case (rng[4:3])
          2'd0:    addr = hl_cfg_pkg::ADDR_CFG;
          2'd2:    addr = rng[10:5];
          default: addr = hl_cfg_pkg::ADDR_AD9866;
        endcase
        frame_q.push_back(hl_cfg_pkg::FRAME_CMD);
        frame_q.push_back({addr, rng[11], rng[12]});
        for (int k = 3; k >= 0; k--) frame_q.push_back(data[8*k +: 8]);
        if (rng[13]) frame_q.push_back(rng[31:24]);
        is_cmd = 1'b1;
      end

      send_frame();
      if (is_cmd) begin
        m_count = m_count + 16'd1;
        m_ptt   = rng[12];
        if (addr == hl_cfg_pkg::ADDR_CFG) begin
          m_cw       = data[0];
          m_conv_rst = data[1];
        end
        if (addr == hl_cfg_pkg::ADDR_AD9866) m_windows++;
        if (rng[11]) begin
          wait_response();
          check_value("response", {addr, m_ptt, 1'b1, hl_cfg_pkg::SERIAL_NO, m_run,
                                   m_run & m_ptt, m_cw, m_clip, m_good, 3'b000, m_count},
                      resp_o);
          m_clip = 1'b0;
          m_good = 1'b0;
          m_resp++;
        end
      end

      idle_gap(80 + int'(rng[20:16]));
      wait_spi_done();
      check_value("run", 40'(m_run), 40'(run_o));
      check_value("tx_on", 40'(m_run & m_ptt), 40'(tx_on_o));
      check_value("cw key", 40'(m_cw), 40'(cw_keydown_o));
      check_value("converter reset", 40'(!m_conv_rst), 40'(ad9866_rst_n_o));
      check_value("response count", 40'(m_resp), 40'(resp_seen));
      check_value("serial windows", 40'(m_windows), 40'(spi_windows));
      if (is_cmd && addr == hl_cfg_pkg::ADDR_AD9866) begin
        check_value("serial word", 40'(data[15:0]), 40'(spi_last));
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
common/hl_cfg_pkg.sv
common/hl_proto_pkg.sv
common/cmd_if.sv
source/cmd_parser.sv
control/ctrl_regs.sv
control/spi_writer.sv
control/resp_builder.sv
source/hl_ctrl_top.sv
bench/hl_ctrl_assertions.sv
bench/tb_hl_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the control path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_hl_ctrl -f sim.f --Mdir obj_dir -o tb_hl_ctrl
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_hl_ctrl
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0
